// ==== hw/arm_pkg.sv ====
`default_nettype none

package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [3:0]  cond_t;
	typedef logic [3:0]  flags_t; // n z c v, msb first

	// bit positions inside flags_t
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	localparam word_t RESET_PC       = 32'h0800_0000;
	localparam word_t PC_READ_OFFSET = 32'd8;
	localparam word_t INSTR_BYTES    = 32'd4;

	localparam reg_idx_t PC_IDX = 4'd15;
	localparam reg_idx_t LR_IDX = 4'd14; // link register for bl

	// data-processing opcodes, bits 24:21
	localparam opcode_t OP_AND = 4'h0;
	localparam opcode_t OP_EOR = 4'h1;
	localparam opcode_t OP_SUB = 4'h2;
	localparam opcode_t OP_RSB = 4'h3;
	localparam opcode_t OP_ADD = 4'h4;
	localparam opcode_t OP_ADC = 4'h5;
	localparam opcode_t OP_SBC = 4'h6;
	localparam opcode_t OP_RSC = 4'h7;
	localparam opcode_t OP_TST = 4'h8;
	localparam opcode_t OP_TEQ = 4'h9;
	localparam opcode_t OP_CMP = 4'ha;
	localparam opcode_t OP_CMN = 4'hb;
	localparam opcode_t OP_ORR = 4'hc;
	localparam opcode_t OP_MOV = 4'hd;
	localparam opcode_t OP_BIC = 4'he;
	localparam opcode_t OP_MVN = 4'hf;

	typedef struct packed {
		logic  read;
		logic  write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic     en;
		reg_idx_t rd;
		word_t    data;
	} wb_t;

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc;
	} issue_t;

	typedef struct packed {
		logic  done;   // instruction retires this cycle
		logic  taken;
		word_t target;
	} redirect_t;

	typedef enum logic [1:0] {
		st_init,
		st_fetch,
		st_exec
	} cpu_state_t;

endpackage

`default_nettype wire

// ==== hw/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
	input  wire arm_pkg::word_t instr,
	input  wire arm_pkg::word_t rm_data,
	input  wire                 carry_in,
	output arm_pkg::word_t      operand,
	output logic                carry_out
);

	logic [4:0]  rot;       // twice the rotate field
	logic [4:0]  amt;       // shift_imm
	logic [63:0] imm_rot;
	logic [63:0] rm_rot;
	logic [32:0] lsl_v;     // bit 32 is the last bit shifted out
	logic [32:0] lsr_v;     // bit 0 is the last bit shifted out
	logic [32:0] asr_v;

	assign rot     = {instr[11:8], 1'b0};
	assign amt     = instr[11:7];
	assign imm_rot = {24'd0, instr[7:0], 24'd0, instr[7:0]} >> rot;
	assign rm_rot  = {rm_data, rm_data} >> amt;
	assign lsl_v   = {1'b0, rm_data} << amt;
	assign lsr_v   = {rm_data, 1'b0} >> amt;
	assign asr_v   = $signed({rm_data, 1'b0}) >>> amt;

	always_comb begin
		if (instr[25]) begin
			operand   = imm_rot[31:0];
			carry_out = (rot == 5'd0) ? carry_in : imm_rot[31];
		end else begin
			case (instr[6:5])
				2'b00: begin   // lsl
					operand   = lsl_v[31:0];
					carry_out = (amt == 5'd0) ? carry_in : lsl_v[32];
				end
				2'b01: begin   // lsr, #0 means #32
					operand   = (amt == 5'd0) ? '0 : lsr_v[32:1];
					carry_out = (amt == 5'd0) ? rm_data[31] : lsr_v[0];
				end
				2'b10: begin   // asr, #0 means #32
					operand   = (amt == 5'd0) ? {32{rm_data[31]}} : asr_v[32:1];
					carry_out = (amt == 5'd0) ? rm_data[31] : asr_v[0];
				end
				default: begin // ror, #0 is rrx
					operand   = (amt == 5'd0) ? {carry_in, rm_data[31:1]} : rm_rot[31:0];
					carry_out = (amt == 5'd0) ? rm_data[0] : rm_rot[31];
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire arm_pkg::opcode_t opcode,
	input  wire arm_pkg::word_t   a,
	input  wire arm_pkg::word_t   b,
	input  wire arm_pkg::flags_t  flags_in,
	input  wire                   shifter_carry,
	output arm_pkg::word_t        result,
	output arm_pkg::flags_t       flags_out,
	output logic                  writes_rd
);

	arm_pkg::word_t x;
	arm_pkg::word_t y;
	logic           cin;
	logic           arith;   // flags come from the adder
	logic [32:0]    sum;

	always_comb begin
		x     = a;
		y     = b;
		cin   = 1'b0;
		arith = 1'b1;
		// subtraction as x + ~y + 1, c is then not-borrow
		case (opcode)
			arm_pkg::OP_SUB, arm_pkg::OP_CMP: begin
				y   = ~b;
				cin = 1'b1;
			end
			arm_pkg::OP_RSB: begin
				x   = b;
				y   = ~a;
				cin = 1'b1;
			end
			arm_pkg::OP_ADD, arm_pkg::OP_CMN: cin = 1'b0;
			arm_pkg::OP_ADC: cin = flags_in[arm_pkg::FLAG_C];
			arm_pkg::OP_SBC: begin
				y   = ~b;
				cin = flags_in[arm_pkg::FLAG_C];
			end
			arm_pkg::OP_RSC: begin
				x   = b;
				y   = ~a;
				cin = flags_in[arm_pkg::FLAG_C];
			end
			default: arith = 1'b0;
		endcase

		sum = {1'b0, x} + {1'b0, y} + {32'd0, cin};

		case (opcode)
			arm_pkg::OP_AND, arm_pkg::OP_TST: result = a & b;
			arm_pkg::OP_EOR, arm_pkg::OP_TEQ: result = a ^ b;
			arm_pkg::OP_ORR: result = a | b;
			arm_pkg::OP_MOV: result = b;
			arm_pkg::OP_BIC: result = a & ~b;
			arm_pkg::OP_MVN: result = ~b;
			default:         result = sum[31:0];
		endcase

		flags_out[arm_pkg::FLAG_N] = result[31];
		flags_out[arm_pkg::FLAG_Z] = (result == '0);
		flags_out[arm_pkg::FLAG_C] = arith ? sum[32] : shifter_carry;
		flags_out[arm_pkg::FLAG_V] = arith ? ((x[31] == y[31]) && (sum[31] != x[31]))
			: flags_in[arm_pkg::FLAG_V];   // logical ops keep v
	end

	// tst, teq, cmp and cmn only set flags
	assign writes_rd = (opcode[3:2] != 2'b10);

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire arm_pkg::reg_idx_t rd_a_idx,
	input  wire arm_pkg::reg_idx_t rd_b_idx,
	input  wire arm_pkg::reg_idx_t rd_c_idx,
	input  wire arm_pkg::wb_t      wb,
	input  wire arm_pkg::wb_t      base_wb,
	output arm_pkg::word_t         rd_a_data,
	output arm_pkg::word_t         rd_b_data,
	output arm_pkg::word_t         rd_c_data
);

	arm_pkg::word_t regs [0:14];   // r0 to r14, pc lives in fetch_unit

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < 15; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (base_wb.en && base_wb.rd != arm_pkg::PC_IDX) begin
				regs[base_wb.rd] <= base_wb.data;
			end
			// a load into the base register wins over the base update
			if (wb.en && wb.rd != arm_pkg::PC_IDX) begin
				regs[wb.rd] <= wb.data;
			end
		end
	end

	assign rd_a_data = (rd_a_idx == arm_pkg::PC_IDX) ? '0 : regs[rd_a_idx];
	assign rd_b_data = (rd_b_idx == arm_pkg::PC_IDX) ? '0 : regs[rd_b_idx];
	assign rd_c_data = (rd_c_idx == arm_pkg::PC_IDX) ? '0 : regs[rd_c_idx];

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire                     mem_ok,
	input  wire arm_pkg::word_t     mem_rdata,
	input  wire arm_pkg::redirect_t redirect,
	output arm_pkg::issue_t         issue,
	output logic                    fetch_req
);

	arm_pkg::cpu_state_t state;
	arm_pkg::word_t      pc;
	arm_pkg::word_t      ir;   // instruction register

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= arm_pkg::st_init;
			pc    <= arm_pkg::RESET_PC;
		end else begin
			case (state)
				arm_pkg::st_init: begin
					state <= arm_pkg::st_fetch;
					pc    <= arm_pkg::RESET_PC;
				end
				arm_pkg::st_fetch: begin
					if (mem_ok) begin
						state <= arm_pkg::st_exec;
					end
				end
				arm_pkg::st_exec: begin
					if (redirect.done) begin
						state <= arm_pkg::st_fetch;
						pc    <= redirect.taken ? redirect.target : pc + arm_pkg::INSTR_BYTES;
					end
				end
				default: state <= arm_pkg::st_init;
			endcase
		end
	end

	// captured on the cycle the fetch completes
	always_ff @(posedge clk) begin
		if (state == arm_pkg::st_fetch && mem_ok) begin
			ir <= mem_rdata;
		end
	end

	always_comb begin
		issue.valid = (state == arm_pkg::st_exec);
		issue.instr = ir;
		issue.pc    = pc;
		fetch_req   = (state == arm_pkg::st_fetch);
	end

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  wire                  clk,
	input  wire                  rstn,
	input  wire arm_pkg::issue_t issue,
	input  wire                  mem_ok,
	input  wire arm_pkg::word_t  mem_rdata,
	input  wire arm_pkg::word_t  rd_a_data,
	input  wire arm_pkg::word_t  rd_b_data,
	input  wire arm_pkg::word_t  rd_c_data,
	output arm_pkg::reg_idx_t    rd_a_idx,
	output arm_pkg::reg_idx_t    rd_b_idx,
	output arm_pkg::reg_idx_t    rd_c_idx,
	output arm_pkg::wb_t         wb,
	output arm_pkg::wb_t         base_wb,
	output arm_pkg::mem_req_t    data_req,
	output arm_pkg::redirect_t   redirect
);

	arm_pkg::word_t  instr;
	arm_pkg::word_t  pc_read;   // r15 as the instruction sees it
	arm_pkg::word_t  rn_val;
	arm_pkg::word_t  rd_val;
	arm_pkg::word_t  rm_val;
	arm_pkg::word_t  shift_op;
	arm_pkg::word_t  alu_res;
	arm_pkg::word_t  ls_upd;    // base +/- offset
	arm_pkg::word_t  ls_addr;
	arm_pkg::flags_t flags;
	arm_pkg::flags_t alu_flags;
	logic            shift_c;
	logic            alu_wr;
	logic            fn;
	logic            fz;
	logic            fc;
	logic            fv;
	logic            pass;
	logic            is_dp;
	logic            is_ls;
	logic            is_br;
	logic            ls_go;

	assign instr    = issue.instr;
	assign pc_read  = issue.pc + arm_pkg::PC_READ_OFFSET;
	assign rd_a_idx = instr[19:16];   // rn
	assign rd_b_idx = instr[15:12];   // rd, store data
	assign rd_c_idx = instr[3:0];     // rm
	assign rn_val   = (rd_a_idx == arm_pkg::PC_IDX) ? pc_read : rd_a_data;
	assign rd_val   = (rd_b_idx == arm_pkg::PC_IDX) ? pc_read : rd_b_data;
	assign rm_val   = (rd_c_idx == arm_pkg::PC_IDX) ? pc_read : rd_c_data;

	assign fn = flags[arm_pkg::FLAG_N];
	assign fz = flags[arm_pkg::FLAG_Z];
	assign fc = flags[arm_pkg::FLAG_C];
	assign fv = flags[arm_pkg::FLAG_V];

	always_comb begin
		case (arm_pkg::cond_t'(instr[31:28]))
			4'h0: pass = fz;
			4'h1: pass = !fz;
			4'h2: pass = fc;
			4'h3: pass = !fc;
			4'h4: pass = fn;
			4'h5: pass = !fn;
			4'h6: pass = fv;
			4'h7: pass = !fv;
			4'h8: pass = fc && !fz;            // hi
			4'h9: pass = !fc || fz;            // ls
			4'ha: pass = (fn == fv);
			4'hb: pass = (fn != fv);
			4'hc: pass = !fz && (fn == fv);    // gt
			4'hd: pass = fz || (fn != fv);
			4'he: pass = 1'b1;
			default: pass = 1'b0;              // nv
		endcase
	end

	// register-shifted operands and msr/mrs space fall through as no-ops
	assign is_dp = (instr[27:26] == 2'b00) && (instr[25] || !instr[4])
		&& !((instr[24:23] == 2'b10) && !instr[20]);
	assign is_ls = (instr[27:25] == 3'b010) && !instr[22];   // word, imm offset
	assign is_br = (instr[27:25] == 3'b101);
	assign ls_go = issue.valid && pass && is_ls;

	assign ls_upd  = instr[23] ? rn_val + {20'd0, instr[11:0]} : rn_val - {20'd0, instr[11:0]};
	assign ls_addr = instr[24] ? ls_upd : rn_val;   // pre or post index

	barrel_shifter u_barrel_shifter (
		.instr     (instr),
		.rm_data   (rm_val),
		.carry_in  (fc),
		.operand   (shift_op),
		.carry_out (shift_c)
	);

	alu u_alu (
		.opcode        (arm_pkg::opcode_t'(instr[24:21])),
		.a             (rn_val),
		.b             (shift_op),
		.flags_in      (flags),
		.shifter_carry (shift_c),
		.result        (alu_res),
		.flags_out     (alu_flags),
		.writes_rd     (alu_wr)
	);

	always_comb begin
		data_req.read  = ls_go && instr[20];
		data_req.write = ls_go && !instr[20];
		data_req.addr  = ls_addr;
		data_req.wdata = rd_val;
	end

	always_comb begin
		wb            = '0;
		base_wb       = '0;
		redirect      = '0;
		redirect.done = issue.valid && (!ls_go || mem_ok);
		if (redirect.done && pass) begin
			if (is_br) begin
				redirect.taken  = 1'b1;
				redirect.target = pc_read + {{6{instr[23]}}, instr[23:0], 2'b00};
				wb.en           = instr[24];   // bl
				wb.rd           = arm_pkg::LR_IDX;
				wb.data         = issue.pc + arm_pkg::INSTR_BYTES;
			end else if (is_dp && alu_wr) begin
				if (rd_b_idx == arm_pkg::PC_IDX) begin
					redirect.taken  = 1'b1;
					redirect.target = {alu_res[31:2], 2'b00};
				end else begin
					wb.en   = 1'b1;
					wb.rd   = rd_b_idx;
					wb.data = alu_res;
				end
			end else if (is_ls) begin
				base_wb.en   = !instr[24] || instr[21];   // post index always writes back
				base_wb.rd   = rd_a_idx;
				base_wb.data = ls_upd;
				if (instr[20] && rd_b_idx == arm_pkg::PC_IDX) begin
					redirect.taken  = 1'b1;
					redirect.target = {mem_rdata[31:2], 2'b00};
				end else begin
					wb.en   = instr[20];
					wb.rd   = rd_b_idx;
					wb.data = mem_rdata;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			flags <= '0;
		end else if (issue.valid && pass && is_dp && instr[20]) begin
			flags <= alu_flags;   // also for s with rd = pc
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire                    fetch_req,
	input  wire arm_pkg::word_t    fetch_addr,
	input  wire arm_pkg::mem_req_t data_req,
	input  wire                    mem_ok,
	output arm_pkg::mem_req_t      mem
);

	logic busy;       // a request is waiting for mem_ok
	logic owner;      // 1 when the data side holds the port
	logic sel_data;
	logic active;

	always_comb begin
		sel_data = busy ? owner : !fetch_req;
		if (sel_data) begin
			mem = data_req;
		end else begin
			mem.read  = fetch_req;
			mem.write = 1'b0;
			mem.addr  = fetch_addr;
			mem.wdata = '0;
		end
		active = mem.read || mem.write;
	end

	// owner stays fixed until the memory answers
	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy  <= 1'b0;
			owner <= 1'b0;
		end else if (mem_ok) begin
			busy <= 1'b0;
		end else if (active) begin
			busy  <= 1'b1;
			owner <= sel_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/arm_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_core (
	input  wire                 clk,
	input  wire                 rstn,
	input  wire                 mem_ok,
	input  wire arm_pkg::word_t mem_rdata,
	output arm_pkg::mem_req_t   mem
);

	arm_pkg::issue_t    issue;
	arm_pkg::redirect_t redirect;
	arm_pkg::mem_req_t  data_req;
	arm_pkg::wb_t       wb;
	arm_pkg::wb_t       base_wb;   // base register update of ldr/str
	arm_pkg::reg_idx_t  rd_a_idx;
	arm_pkg::reg_idx_t  rd_b_idx;
	arm_pkg::reg_idx_t  rd_c_idx;
	arm_pkg::word_t     rd_a_data;
	arm_pkg::word_t     rd_b_data;
	arm_pkg::word_t     rd_c_data;
	logic               fetch_req;

	fetch_unit u_fetch_unit (
		.clk       (clk),
		.rstn      (rstn),
		.mem_ok    (mem_ok),
		.mem_rdata (mem_rdata),
		.redirect  (redirect),
		.issue     (issue),
		.fetch_req (fetch_req)
	);

	exec_unit u_exec_unit (
		.clk       (clk),
		.rstn      (rstn),
		.issue     (issue),
		.mem_ok    (mem_ok),
		.mem_rdata (mem_rdata),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.rd_c_data (rd_c_data),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_c_idx  (rd_c_idx),
		.wb        (wb),
		.base_wb   (base_wb),
		.data_req  (data_req),
		.redirect  (redirect)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rstn      (rstn),
		.rd_a_idx  (rd_a_idx),
		.rd_b_idx  (rd_b_idx),
		.rd_c_idx  (rd_c_idx),
		.wb        (wb),
		.base_wb   (base_wb),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.rd_c_data (rd_c_data)
	);

	mem_access u_mem_access (
		.clk        (clk),
		.rstn       (rstn),
		.fetch_req  (fetch_req),
		.fetch_addr (issue.pc),   // fetch address is the current pc
		.data_req   (data_req),
		.mem_ok     (mem_ok),
		.mem        (mem)
	);

endmodule

`default_nettype wire

// ==== verif/arm_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_assert (
	input wire                    clk,
	input wire                    rstn,
	input wire arm_pkg::mem_req_t mem,
	input wire                    mem_ok
);

	// one direction per request
	a_one_dir: assert property (@(posedge clk) disable iff (!rstn)
		!(mem.read && mem.write))
		else $error("memory read and write requested in the same cycle");

	// request must hold until the memory answers
	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		((mem.read || mem.write) && !mem_ok) |=> ($stable(mem.addr) && $stable(mem.wdata)))
		else $error("memory address or write data changed while waiting for mem_ok");

	a_quiet_reset: assert property (@(posedge clk)
		!rstn |-> !(mem.read || mem.write))
		else $error("memory request made while in reset");

endmodule

`default_nettype wire

// ==== verif/arm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm_checker (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire arm_pkg::mem_req_t mem,
	input  wire                    mem_ok,
	input  wire arm_pkg::word_t    prog [0:255],
	input  wire arm_pkg::word_t    prog_len,
	output logic                   done,
	output int                     err_count,
	output int                     write_count
);

	localparam arm_pkg::word_t END_ADDR = 32'h0000_fffc;

	arm_pkg::word_t exp_addr [$];
	arm_pkg::word_t exp_data [$];
	arm_pkg::word_t ref_regs [0:15];
	arm_pkg::word_t ref_mem [arm_pkg::word_t];
	logic           fl_n;
	logic           fl_z;
	logic           fl_c;
	logic           fl_v;
	logic           seen_first;
	int             cmp_errors;
	int             ref_errors;

	assign err_count = cmp_errors + ref_errors;

	// same pattern as the memory model in tb_top
	function automatic arm_pkg::word_t fill_word(input arm_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_0000;
	endfunction

	function automatic logic cond_ok(input logic [3:0] cc);
		case (cc)
			4'h0: return fl_z;
			4'h1: return !fl_z;
			4'h2: return fl_c;
			4'h3: return !fl_c;
			4'h4: return fl_n;
			4'h5: return !fl_n;
			4'h6: return fl_v;
			4'h7: return !fl_v;
			4'h8: return fl_c && !fl_z;
			4'h9: return !fl_c || fl_z;
			4'ha: return fl_n == fl_v;
			4'hb: return fl_n != fl_v;
			4'hc: return !fl_z && (fl_n == fl_v);
			4'hd: return fl_z || (fl_n != fl_v);
			4'he: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// {carry, value} of operand 2
	function automatic logic [32:0] operand2(input arm_pkg::word_t ins, input arm_pkg::word_t rmv,
		input logic cin);
		logic [4:0]     rot;
		logic [4:0]     amt;
		arm_pkg::word_t x;
		arm_pkg::word_t t;
		logic [32:0]    w;
		logic           co;
		rot = {ins[11:8], 1'b0};
		amt = ins[11:7];
		if (ins[25]) begin
			x  = {24'd0, ins[7:0]};
			co = cin;
			if (rot != 5'd0) begin
				x  = (x >> rot) | (x << (6'd32 - rot));
				co = x[31];
			end
		end else if (ins[6:5] == 2'b00) begin
			w  = {1'b0, rmv} << amt;
			x  = w[31:0];
			co = (amt == 5'd0) ? cin : w[32];
		end else if (amt == 5'd0) begin   // lsr/asr #32 and rrx
			case (ins[6:5])
				2'b01:   x = '0;
				2'b10:   x = {32{rmv[31]}};
				default: x = {cin, rmv[31:1]};
			endcase
			co = (ins[6:5] == 2'b11) ? rmv[0] : rmv[31];
		end else begin
			case (ins[6:5])
				2'b01: begin
					x = rmv >> amt;
					t = rmv >> (amt - 5'd1);
				end
				2'b10: begin
					x = $signed(rmv) >>> amt;
					t = $signed(rmv) >>> (amt - 5'd1);
				end
				default: begin
					x = (rmv >> amt) | (rmv << (6'd32 - amt));
					t = {31'd0, x[31]};
				end
			endcase
			co = t[0];
		end
		return {co, x};
	endfunction

	function automatic void run_reference();
		arm_pkg::word_t pc;
		arm_pkg::word_t next;
		arm_pkg::word_t ins;
		arm_pkg::word_t a;
		arm_pkg::word_t b;
		arm_pkg::word_t res;
		arm_pkg::word_t upd;
		arm_pkg::word_t addr;
		arm_pkg::word_t sdata;
		arm_pkg::word_t idx;
		logic [32:0]    sh;
		logic [32:0]    t;
		logic [3:0]     op;
		logic           cf;
		logic           vf;
		logic           fin;
		int             steps;
		for (int i = 0; i < 16; i++) begin
			ref_regs[i] = '0;
		end
		{fl_n, fl_z, fl_c, fl_v} = 4'b0000;
		pc    = arm_pkg::RESET_PC;
		fin   = 1'b0;
		steps = 0;
		while (!fin && steps < 200000) begin
			idx = (pc - arm_pkg::RESET_PC) >> 2;
			if (pc < arm_pkg::RESET_PC || idx >= prog_len) begin
				$display("reference model ran outside the program at %h", pc);
				ref_errors++;
				break;
			end
			ins          = prog[idx[7:0]];
			steps++;
			next         = pc + 32'd4;
			ref_regs[15] = pc + 32'd8;
			if (cond_ok(ins[31:28])) begin
				if (ins[27:26] == 2'b00) begin
					op  = ins[24:21];
					a   = ref_regs[ins[19:16]];
					sh  = operand2(ins, ref_regs[ins[3:0]], fl_c);
					b   = sh[31:0];
					cf  = sh[32];
					vf  = fl_v;
					res = '0;
					case (op)
						arm_pkg::OP_AND, arm_pkg::OP_TST: res = a & b;
						arm_pkg::OP_EOR, arm_pkg::OP_TEQ: res = a ^ b;
						arm_pkg::OP_ORR: res = a | b;
						arm_pkg::OP_MOV: res = b;
						arm_pkg::OP_BIC: res = a & ~b;
						arm_pkg::OP_MVN: res = ~b;
						arm_pkg::OP_ADD, arm_pkg::OP_CMN, arm_pkg::OP_ADC: begin
							t   = {1'b0, a} + {1'b0, b} + {32'd0, (op == arm_pkg::OP_ADC) && fl_c};
							res = t[31:0];
							cf  = t[32];
							vf  = (a[31] == b[31]) && (res[31] != a[31]);
						end
						arm_pkg::OP_SUB, arm_pkg::OP_CMP, arm_pkg::OP_SBC: begin
							t   = {1'b0, a} - {1'b0, b} - {32'd0, (op == arm_pkg::OP_SBC) && !fl_c};
							res = t[31:0];
							cf  = !t[32];   // no borrow
							vf  = (a[31] != b[31]) && (res[31] != a[31]);
						end
						default: begin   // rsb, rsc
							t   = {1'b0, b} - {1'b0, a} - {32'd0, (op == arm_pkg::OP_RSC) && !fl_c};
							res = t[31:0];
							cf  = !t[32];
							vf  = (a[31] != b[31]) && (res[31] != b[31]);
						end
					endcase
					if (ins[20]) begin
						{fl_n, fl_z, fl_c, fl_v} = {res[31], res == 32'd0, cf, vf};
					end
					if (!(op inside {arm_pkg::OP_TST, arm_pkg::OP_TEQ, arm_pkg::OP_CMP,
						arm_pkg::OP_CMN})) begin
						if (ins[15:12] == 4'd15) begin
							next = {res[31:2], 2'b00};
						end else begin
							ref_regs[ins[15:12]] = res;
						end
					end
				end else if (ins[27:25] == 3'b010) begin
					a     = ref_regs[ins[19:16]];
					sdata = ref_regs[ins[15:12]];
					upd   = ins[23] ? a + {20'd0, ins[11:0]} : a - {20'd0, ins[11:0]};
					addr  = ins[24] ? upd : a;
					if (!ins[24] || ins[21]) begin
						ref_regs[ins[19:16]] = upd;
					end
					if (ins[20]) begin
						ref_regs[ins[15:12]] = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
					end else begin
						exp_addr.push_back(addr);
						exp_data.push_back(sdata);
						ref_mem[addr] = sdata;
						fin = (addr == END_ADDR);
					end
				end else if (ins[27:25] == 3'b101) begin
					if (ins[24]) begin
						ref_regs[14] = pc + 32'd4;   // bl link
					end
					next = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
				end
			end
			pc = next;
		end
		if (!fin) begin
			$display("reference model never reached the end address");
			ref_errors++;
		end
	endfunction

	initial begin
		ref_errors = 0;
		@(posedge rstn);
		run_reference();
	end

	always @(posedge clk) begin
		if (!rstn) begin
			done        = 1'b0;
			cmp_errors  = 0;
			write_count = 0;
			seen_first  = 1'b0;
		end else if (!done) begin
			if (!seen_first && (mem.read || mem.write)) begin
				seen_first = 1'b1;
				if (!mem.read || mem.addr != arm_pkg::RESET_PC) begin
					$display("ERROR %0t: first request is not a read at %h (addr %h)",
						$time, arm_pkg::RESET_PC, mem.addr);
					cmp_errors++;
				end
			end
			if (mem.write && mem_ok) begin
				if (write_count >= exp_addr.size()) begin
					$display("the core wrote %h to %h after all expected writes", mem.wdata, mem.addr);
					cmp_errors++;
				end else if (mem.addr != exp_addr[write_count] || mem.wdata != exp_data[write_count]) begin
					$display("ERROR %0t: write %0d got %h at %h, expected %h at %h", $time,
						write_count, mem.wdata, mem.addr, exp_data[write_count], exp_addr[write_count]);
					cmp_errors++;
				end
				write_count++;
				if (mem.addr == END_ADDR) begin
					done = 1'b1;
					if (write_count != exp_addr.size()) begin
						$display("the core stopped after %0d writes, %0d were expected", write_count,
							exp_addr.size());
						cmp_errors++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	logic              clk = 1'b0;
	logic              rstn;
	logic              mem_ok = 1'b0;
	arm_pkg::word_t    mem_rdata = '0;
	arm_pkg::mem_req_t dut_mem;

	arm_pkg::word_t prog [0:255];
	arm_pkg::word_t prog_len;
	arm_pkg::word_t dmem [arm_pkg::word_t];
	arm_pkg::word_t prog_seed = 32'd22;
	arm_pkg::word_t delay_seed = 32'd22;   // separate stream for mem_ok delays
	arm_pkg::word_t limit;
	arm_pkg::word_t cycles;
	logic [1:0]     wait_left;
	logic           pending;
	logic           chk_done;
	int             chk_errors;
	int             chk_writes;

	always #4 clk = ~clk;

	arm_core u_arm_core (
		.clk       (clk),
		.rstn      (rstn),
		.mem_ok    (mem_ok),
		.mem_rdata (mem_rdata),
		.mem       (dut_mem)
	);

	arm_checker u_arm_checker (
		.clk         (clk),
		.rstn        (rstn),
		.mem         (dut_mem),
		.mem_ok      (mem_ok),
		.prog        (prog),
		.prog_len    (prog_len),
		.done        (chk_done),
		.err_count   (chk_errors),
		.write_count (chk_writes)
	);

	bind arm_core arm_assert u_arm_assert (.clk(clk), .rstn(rstn), .mem(mem), .mem_ok(mem_ok));

	function automatic arm_pkg::word_t lcg(input arm_pkg::word_t s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic arm_pkg::word_t fill_word(input arm_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_0000;
	endfunction

	function automatic arm_pkg::word_t imm_dp_instr(input logic [3:0] cond, input logic [3:0] op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
		input logic [7:0] imm);
		return {cond, 3'b001, op, s, rn, rd, rot, imm};
	endfunction

	function automatic arm_pkg::word_t shifted_dp_instr(input logic [3:0] cond,
		input logic [3:0] op, input logic s, input logic [3:0] rn, input logic [3:0] rd,
		input logic [4:0] amt, input logic [1:0] sh, input logic [3:0] rm);
		return {cond, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
	endfunction

	function automatic arm_pkg::word_t ldr_str_instr(input logic p, input logic u, input logic w,
		input logic l, input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
		return {4'he, 3'b010, p, u, 1'b0, w, l, rn, rd, off};
	endfunction

	function automatic arm_pkg::word_t branch_instr(input logic [3:0] cond, input logic link,
		input logic [23:0] off);
		return {cond, 3'b101, link, off};
	endfunction

	task automatic emit(input arm_pkg::word_t w);
		prog[prog_len[7:0]] = w;
		prog_len = prog_len + 32'd1;
	endtask

	task automatic next_rand(output arm_pkg::word_t v);
		prog_seed = lcg(prog_seed);
		v = prog_seed >> 8;
	endtask

	// post-indexed store through r10 into the result stream
	task automatic store_next(input logic [3:0] rd);
		emit(ldr_str_instr(1'b0, 1'b1, 1'b0, 1'b0, 4'd10, rd, 12'd4));
	endtask

	task automatic build_program();
		arm_pkg::word_t r;
		arm_pkg::word_t s;
		arm_pkg::word_t setters [0:2];
		for (int i = 0; i < 256; i++) begin
			prog[i] = '0;
		end
		prog_len = '0;
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd10, 4'd10, 8'd1));  // r10 = 0x1000
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd11, 4'd8, 8'd1));   // r11 = 0x10000
		next_rand(r);
		emit(imm_dp_instr(4'he, arm_pkg::OP_MVN, 1'b0, 4'd0, 4'd1, r[11:8], r[7:0]));
		next_rand(r);
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd2, r[11:8], r[7:0]));
		for (int op = 0; op < 16; op++) begin
			next_rand(r);
			emit(imm_dp_instr(4'he, 4'(op), 1'b1, 4'd1, 4'd3, r[11:8], r[7:0]));
			store_next(4'd3);
		end
		// each shift type with a random amount and with amount zero
		for (int sh = 0; sh < 4; sh++) begin
			next_rand(r);
			emit(shifted_dp_instr(4'he, arm_pkg::OP_MOV, 1'b1, 4'd0, 4'd4, r[4:0], 2'(sh), 4'd1));
			emit(imm_dp_instr(4'he, arm_pkg::OP_ADC, 1'b0, 4'd4, 4'd4, 4'd0, 8'd0));  // adds shifter c
			store_next(4'd4);
			emit(shifted_dp_instr(4'he, arm_pkg::OP_MOV, 1'b1, 4'd0, 4'd4, 5'd0, 2'(sh), 4'd2));
			emit(imm_dp_instr(4'he, arm_pkg::OP_ADC, 1'b0, 4'd4, 4'd4, 4'd0, 8'd0));
			store_next(4'd4);
		end
		setters[0] = shifted_dp_instr(4'he, arm_pkg::OP_CMP, 1'b1, 4'd1, 4'd0, 5'd0, 2'b00, 4'd2);
		setters[1] = shifted_dp_instr(4'he, arm_pkg::OP_CMP, 1'b1, 4'd2, 4'd0, 5'd0, 2'b00, 4'd1);
		setters[2] = shifted_dp_instr(4'he, arm_pkg::OP_CMN, 1'b1, 4'd1, 4'd0, 5'd0, 2'b00, 4'd1);
		for (int k = 0; k < 3; k++) begin
			emit(setters[k]);
			for (int cc = 0; cc < 15; cc++) begin
				emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd5, 4'd0, 8'd0));
				emit(imm_dp_instr(4'(cc), arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd5, 4'd0, 8'(cc + 1)));
				store_next(4'd5);
			end
		end
		for (int k = 0; k < 2; k++) begin
			next_rand(r);
			next_rand(s);
			emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd6, 4'd10, 8'd2));   // r6 = 0x2000
			emit(ldr_str_instr(1'b1, 1'b1, 1'b1, 1'b0, 4'd6, 4'd1, {6'd0, r[3:0], 2'b00}));
			emit(ldr_str_instr(1'b0, 1'b0, 1'b0, 1'b0, 4'd6, 4'd2, {6'd0, r[7:4], 2'b00}));
			emit(ldr_str_instr(1'b1, 1'b1, 1'b0, 1'b1, 4'd6, 4'd7, {6'd0, r[11:8], 2'b00}));
			emit(ldr_str_instr(1'b0, 1'b1, 1'b0, 1'b1, 4'd6, 4'd8, {6'd0, s[3:0], 2'b00}));
			emit(ldr_str_instr(1'b1, 1'b0, 1'b1, 1'b1, 4'd6, 4'd9, {6'd0, s[7:4], 2'b00}));
			store_next(4'd6);
			store_next(4'd7);
			store_next(4'd8);
			store_next(4'd9);
		end
		emit(imm_dp_instr(4'he, arm_pkg::OP_ADD, 1'b0, 4'd15, 4'd13, 4'd0, 8'd0));   // r13 = pc + 8
		store_next(4'd13);
		next_rand(r);
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd12, 4'd0, 8'd3 + 8'(r % 5)));
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
		emit(imm_dp_instr(4'he, arm_pkg::OP_ADD, 1'b0, 4'd0, 4'd0, 4'd0, 8'd3));   // loop body
		emit(imm_dp_instr(4'he, arm_pkg::OP_SUB, 1'b1, 4'd12, 4'd12, 4'd0, 8'd1));
		emit(branch_instr(4'h1, 1'b0, 24'hff_fffc));   // bne back to the add
		store_next(4'd0);
		store_next(4'd12);
		emit(branch_instr(4'he, 1'b1, 24'd0));   // bl over the next word
		emit(imm_dp_instr(4'he, arm_pkg::OP_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'h55));
		store_next(4'd14);
		store_next(4'd0);
		emit(ldr_str_instr(1'b1, 1'b0, 1'b0, 1'b0, 4'd11, 4'd0, 12'd4));   // end marker at 0xfffc
		emit(branch_instr(4'he, 1'b0, 24'hff_fffe));
	endtask

	function automatic arm_pkg::word_t read_word(input arm_pkg::word_t a);
		arm_pkg::word_t idx;
		idx = (a - arm_pkg::RESET_PC) >> 2;
		if (a >= arm_pkg::RESET_PC && idx < 32'd256) begin
			return prog[idx[7:0]];
		end
		return dmem.exists(a) ? dmem[a] : fill_word(a);
	endfunction

	// memory answers after 0 to 3 wait cycles
	always @(negedge clk) begin
		if (!rstn) begin
			mem_ok  <= 1'b0;
			pending = 1'b0;
		end else if (mem_ok) begin
			mem_ok  <= 1'b0;
			pending = 1'b0;
		end else if (dut_mem.read || dut_mem.write) begin
			if (!pending) begin
				pending    = 1'b1;
				delay_seed = lcg(delay_seed);
				wait_left  = delay_seed[17:16];
			end
			if (wait_left == 2'd0) begin
				mem_ok <= 1'b1;
				if (dut_mem.read) begin
					mem_rdata <= read_word(dut_mem.addr);
				end else begin
					dmem[dut_mem.addr] = dut_mem.wdata;
				end
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rstn) begin
			cycles <= '0;
		end else begin
			cycles <= cycles + 32'd1;
		end
	end

	initial begin
		rstn = 1'b0;
		build_program();
		limit = 32'd120 * prog_len;   // 20 x words x 6
		repeat (8) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);
		while (!chk_done && cycles < limit) begin
			@(negedge clk);
		end
		if (!chk_done) begin
			$display("timeout: end address not written within %0d cycles", limit);
		end
		$display("errors: %0d, writes checked: %0d", chk_errors, chk_writes);
		if (chk_done && chk_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/arm_pkg.sv
hw/barrel_shifter.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/exec_unit.sv
hw/mem_access.sv
hw/arm_core.sv
verif/arm_assert.sv
verif/arm_checker.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ARM core testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f list.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
